// File: hw/degu_bus_pkg.sv
// Degu load/store bus definitions

`default_nettype none

package degu_bus_pkg;

  //////////////////////////////////////////////////
  // widths and address map
  //////////////////////////////////////////////////

  // data and address width
  localparam int unsigned XLEN = 32;
  // bytes per word, and byte offset bits
  localparam int unsigned BLEN = XLEN/8;
  localparam int unsigned BLOG = $clog2(BLEN);

  // data memory word address width (4096 words, 16 KiB)
  localparam int unsigned MEM_ABW = 12;

  // peripheral window over data memory
  localparam int unsigned PER_SEL_BIT = 14;
  // UART window over GPIO, inside the peripheral window
  localparam int unsigned UART_SEL_BIT = 6;

  // GPIO pin count
  localparam int unsigned GPIO_W = 32;

  //////////////////////////////////////////////////
  // basic types
  //////////////////////////////////////////////////

  typedef logic [XLEN-1:0]    addr_t;
  typedef logic [XLEN-1:0]    data_t;
  typedef logic [BLEN-1:0]    ben_t;
  typedef logic [MEM_ABW-1:0] mem_adr_t;
  typedef logic [GPIO_W-1:0]  gpio_t;

  // GPIO register map, address bits 3:2
  typedef enum logic [1:0] {
    GPIO_OUT  = 2'd0,  // 0x0 output value
    GPIO_ENA  = 2'd1,  // 0x4 output enable
    GPIO_IN   = 2'd2,  // 0x8 synchronized input, read only
    GPIO_NONE = 2'd3   // 0xC unmapped, reads zero
  } gpio_reg_e;

  //////////////////////////////////////////////////
  // bus request and response
  //////////////////////////////////////////////////

  // request, driven by the manager with vld
  typedef struct packed {
    logic  wen;  // write enable
    addr_t adr;  // byte address
    ben_t  ben;  // byte enables
    data_t wdt;  // write data
  } bus_req_t;

  // response, valid after the segment's fixed delay
  typedef struct packed {
    data_t rdt;  // read data
    logic  err;  // error status
  } bus_rsp_t;

endpackage: degu_bus_pkg

`default_nettype wire

// File: hw/lsu_demux.sv
// Load/store bus demultiplexer

`default_nettype none
`timescale 1ns/1ps

module lsu_demux
  import degu_bus_pkg::*;
(
  // system signals
  input  logic     clk,
  input  logic     rst_n,
  // upstream, from the load/store port
  input  logic     vld,
  input  bus_req_t req,
  output logic     rdy,
  output bus_rsp_t rsp,
  // data memory side
  output logic     mem_vld,
  output bus_req_t mem_req,
  input  logic     mem_rdy,
  input  bus_rsp_t mem_rsp,
  // peripheral side
  output logic     per_vld,
  output bus_req_t per_req,
  input  logic     per_rdy,
  input  bus_rsp_t per_rsp
);

  //////////////////////////////////////////////////
  // request decode
  //////////////////////////////////////////////////

  // 1 selects the peripheral window
  logic sel;
  // target chosen at the last transfer
  logic sel_q;
  // handshake on the upstream port
  logic transfer;

  assign sel = req.adr[PER_SEL_BIT];

  // only the selected target sees vld
  assign mem_vld = vld & ~sel;
  assign per_vld = vld &  sel;

  // request payload goes to both targets
  assign mem_req = req;
  assign per_req = req;

  // ready comes back from the addressed target
  assign rdy = sel ? per_rdy : mem_rdy;

  assign transfer = vld & rdy;

  //////////////////////////////////////////////////
  // response routing
  //////////////////////////////////////////////////

  // remember the target for the DLY=1 response
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sel_q <= 1'b0;
    end else if (transfer) begin
      sel_q <= sel;
    end
  end

  // response cycle follows the transfer cycle
  // so sel_q already holds the matching target
  assign rsp = sel_q ? per_rsp : mem_rsp;

endmodule: lsu_demux

`default_nettype wire

// File: hw/data_memory.sv
// Data memory

`default_nettype none
`timescale 1ns/1ps

module data_memory
  import degu_bus_pkg::*;
(
  // system signals
  input  logic     clk,
  input  logic     rst_n,
  // DLY=1 bus
  input  logic     vld,
  input  bus_req_t req,
  output logic     rdy,
  output bus_rsp_t rsp
);

  //////////////////////////////////////////////////
  // storage and address
  //////////////////////////////////////////////////

  // 4096 words, one port
  data_t    mem [2**MEM_ABW];
  // word index, upper address bits alias
  mem_adr_t adr;
  // registered read data
  data_t    rdt_q;
  // handshake
  logic     transfer;

  assign adr = req.adr[MEM_ABW+BLOG-1:BLOG];

  // always accepts a request
  assign rdy = 1'b1;

  assign transfer = vld & rdy;

  //////////////////////////////////////////////////
  // write and read ports
  //////////////////////////////////////////////////

  // byte-wise write at the transfer edge
  always_ff @(posedge clk) begin
    if (transfer && req.wen) begin
      for (int b = 0; b < BLEN; b++) begin
        if (req.ben[b]) mem[adr][8*b +: 8] <= req.wdt[8*b +: 8];
      end
    end
  end

  // read-first: writes return the old word
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rdt_q <= '0;
    end else if (transfer) begin
      rdt_q <= mem[adr];
    end
  end

  // memory never reports an error
  assign rsp = '{rdt: rdt_q, err: 1'b0};

endmodule: data_memory

`default_nettype wire

// File: hw/peripheral_bus.sv
// Peripheral bus with request register

`default_nettype none
`timescale 1ns/1ps

module peripheral_bus
  import degu_bus_pkg::*;
(
  // system signals
  input  logic     clk,
  input  logic     rst_n,
  // upstream DLY=1 bus, from the demultiplexer
  input  logic     vld,
  input  bus_req_t req,
  output logic     rdy,
  output bus_rsp_t rsp,
  // GPIO controller, DLY=0
  output logic     gpio_vld,
  output bus_req_t gpio_req,
  input  data_t    gpio_rdt
);

  //////////////////////////////////////////////////
  // request register
  //////////////////////////////////////////////////

  // upstream handshake
  logic     transfer;
  // registered request, drives the DLY=0 side
  logic     vld_q;
  bus_req_t req_q;

  // DLY=0 targets are always ready
  // so the register can take a request every cycle
  assign rdy = 1'b1;

  assign transfer = vld & rdy;

  // valid flag, one cycle after each transfer
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      vld_q <= 1'b0;
    end else begin
      vld_q <= transfer;
    end
  end

  // request payload
  always_ff @(posedge clk) begin
    if (transfer) begin
      req_q <= req;
    end
  end

  //////////////////////////////////////////////////
  // GPIO/UART window decode
  //////////////////////////////////////////////////

  // 1 selects the UART window
  logic uart_sel;

  assign uart_sel = req_q.adr[UART_SEL_BIT];

  // GPIO sees only its own window
  assign gpio_vld = vld_q & ~uart_sel;
  assign gpio_req = req_q;

  //////////////////////////////////////////////////
  // response
  //////////////////////////////////////////////////

  // combinational, valid in the cycle after the upstream transfer
  // missing UART answers with an error and zero data
  always_comb begin
    if (uart_sel) begin
      rsp.rdt = '0;
      rsp.err = 1'b1;
    end else begin
      rsp.rdt = gpio_rdt;
      rsp.err = 1'b0;
    end
  end

endmodule: peripheral_bus

`default_nettype wire

// File: hw/gpio_controller.sv
// GPIO controller

`default_nettype none
`timescale 1ns/1ps

module gpio_controller
  import degu_bus_pkg::*;
(
  // system signals
  input  logic     clk,
  input  logic     rst_n,
  // DLY=0 bus
  input  logic     vld,
  input  bus_req_t req,
  output data_t    rdt,
  // GPIO pins
  output gpio_t    gpio_o,
  output gpio_t    gpio_e,
  input  gpio_t    gpio_i
);

  //////////////////////////////////////////////////
  // register select
  //////////////////////////////////////////////////

  // register addressed by bits 3:2
  gpio_reg_e sel;
  // write strobe
  logic      wen;

  assign sel = gpio_reg_e'(req.adr[3:2]);
  assign wen = vld & req.wen;

  // merge enabled bytes of wdt into a register value
  function automatic gpio_t byte_merge(gpio_t old, data_t wdt, ben_t ben);
    gpio_t val;
    val = old;
    for (int b = 0; b < BLEN; b++) begin
      if (ben[b]) val[8*b +: 8] = wdt[8*b +: 8];
    end
    return val;
  endfunction: byte_merge

  //////////////////////////////////////////////////
  // output and enable registers
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      gpio_o <= '0;
      gpio_e <= '0;
    end else if (wen) begin
      case (sel)
        GPIO_OUT: gpio_o <= byte_merge(gpio_o, req.wdt, req.ben);
        GPIO_ENA: gpio_e <= byte_merge(gpio_e, req.wdt, req.ben);
        // input and unmapped slots are read only
        default: ;
      endcase
    end
  end

  //////////////////////////////////////////////////
  // input synchronizer
  //////////////////////////////////////////////////

  // two flops for the asynchronous pins
  gpio_t gpio_s1;
  gpio_t gpio_s2;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      gpio_s1 <= '0;
      gpio_s2 <= '0;
    end else begin
      gpio_s1 <= gpio_i;
      gpio_s2 <= gpio_s1;
    end
  end

  // read mux in the cycle of the request
  always_comb begin
    case (sel)
      GPIO_OUT:  rdt = gpio_o;
      GPIO_ENA:  rdt = gpio_e;
      GPIO_IN:   rdt = gpio_s2;
      // unmapped slot reads zero
      default:   rdt = '0;
    endcase
  end

endmodule: gpio_controller

`default_nettype wire

// File: hw/degu_bus_top.sv
// Degu load/store bus top level

`default_nettype none
`timescale 1ns/1ps

module degu_bus_top
  import degu_bus_pkg::*;
(
  // system signals
  input  logic     clk,
  input  logic     rst_n,
  // load/store port, DLY=1
  input  logic     vld,
  input  bus_req_t req,
  output logic     rdy,
  output bus_rsp_t rsp,
  // GPIO pins
  output gpio_t    gpio_o,
  output gpio_t    gpio_e,
  input  gpio_t    gpio_i
);

  //////////////////////////////////////////////////
  // bus segments
  //////////////////////////////////////////////////

  // demux to data memory, DLY=1
  logic     mem_vld;
  bus_req_t mem_req;
  logic     mem_rdy;
  bus_rsp_t mem_rsp;

  // demux to peripheral bus, DLY=1
  logic     per_vld;
  bus_req_t per_req;
  logic     per_rdy;
  bus_rsp_t per_rsp;

  // peripheral bus to GPIO, DLY=0
  logic     gpio_vld;
  bus_req_t gpio_req;
  data_t    gpio_rdt;

  //////////////////////////////////////////////////
  // instances
  //////////////////////////////////////////////////

  // memory/peripheral split on address bit 14
  lsu_demux lsu_dmx (
    .clk     (clk),
    .rst_n   (rst_n),
    .vld     (vld),
    .req     (req),
    .rdy     (rdy),
    .rsp     (rsp),
    .mem_vld (mem_vld),
    .mem_req (mem_req),
    .mem_rdy (mem_rdy),
    .mem_rsp (mem_rsp),
    .per_vld (per_vld),
    .per_req (per_req),
    .per_rdy (per_rdy),
    .per_rsp (per_rsp)
  );

  // 16 KiB data RAM
  data_memory dmem (
    .clk   (clk),
    .rst_n (rst_n),
    .vld   (mem_vld),
    .req   (mem_req),
    .rdy   (mem_rdy),
    .rsp   (mem_rsp)
  );

  // request register and GPIO/UART decode
  peripheral_bus pbus (
    .clk      (clk),
    .rst_n    (rst_n),
    .vld      (per_vld),
    .req      (per_req),
    .rdy      (per_rdy),
    .rsp      (per_rsp),
    .gpio_vld (gpio_vld),
    .gpio_req (gpio_req),
    .gpio_rdt (gpio_rdt)
  );

  // GPIO registers and pins
  gpio_controller gpio (
    .clk    (clk),
    .rst_n  (rst_n),
    .vld    (gpio_vld),
    .req    (gpio_req),
    .rdt    (gpio_rdt),
    .gpio_o (gpio_o),
    .gpio_e (gpio_e),
    .gpio_i (gpio_i)
  );

endmodule: degu_bus_top

`default_nettype wire

// File: dv/degu_bus_model.svh
// Bus reference model

`ifndef DEGU_BUS_MODEL_SVH
`define DEGU_BUS_MODEL_SVH

// expected memory words and GPIO registers
data_t model_mem [2**MEM_ABW];
gpio_t model_gpio_o;
gpio_t model_gpio_e;

// byte enables widened to a bit mask
function automatic data_t ben_mask(ben_t ben);
  data_t m;
  for (int b = 0; b < BLEN; b++) begin
    m[8*b +: 8] = {8{ben[b]}};
  end
  return m;
endfunction

// read of the synchronized GPIO input
function automatic logic reads_gpio_in(bus_req_t rq);
  return rq.adr[PER_SEL_BIT] && !rq.adr[UART_SEL_BIT] && !rq.wen &&
         (gpio_reg_e'(rq.adr[3:2]) == GPIO_IN);
endfunction

// one transfer, in bus order
// response is formed from the state before its own write
function automatic bus_rsp_t model_access(bus_req_t rq, gpio_t pins);
  bus_rsp_t r;
  data_t    m;
  mem_adr_t idx;
  m   = ben_mask(rq.ben);
  idx = rq.adr[MEM_ABW+BLOG-1:BLOG];
  r   = '{rdt: '0, err: 1'b0};
  if (!rq.adr[PER_SEL_BIT]) begin
    // read-first data memory
    r.rdt = model_mem[idx];
    if (rq.wen) model_mem[idx] = (model_mem[idx] & ~m) | (rq.wdt & m);
  end else if (rq.adr[UART_SEL_BIT]) begin
    // empty UART window
    r.err = 1'b1;
  end else begin
    case (gpio_reg_e'(rq.adr[3:2]))
      GPIO_OUT: begin
        r.rdt = model_gpio_o;
        if (rq.wen) model_gpio_o = (model_gpio_o & ~m) | (rq.wdt & m);
      end
      GPIO_ENA: begin
        r.rdt = model_gpio_e;
        if (rq.wen) model_gpio_e = (model_gpio_e & ~m) | (rq.wdt & m);
      end
      GPIO_IN: r.rdt = pins;
      default: r.rdt = '0;
    endcase
  end
  return r;
endfunction

`endif

// File: dv/degu_bus_tb.sv
// Degu bus testbench

`default_nettype none
`timescale 1ns/1ps

module degu_bus_tb
  import degu_bus_pkg::*;
();

  //////////////////////////////////////////////////
  // run length and timing
  //////////////////////////////////////////////////

  localparam int CLK_PERIOD = 10;
  localparam int RST_CYCLES = 16;
  localparam int N_FILL     = 2**MEM_ABW;
  localparam int N_MEM      = 2000;
  localparam int N_GPIO     = 1000;
  localparam int N_UART     = 200;
  localparam int N_MIX      = 4000;
  localparam int N_DRAIN    = 3;
  localparam int N_CYCLES   = RST_CYCLES + N_FILL + N_MEM + N_GPIO + N_UART + N_MIX + N_DRAIN;
  localparam int TIMEOUT_NS = (N_CYCLES + 100) * CLK_PERIOD;
  localparam int unsigned SEED = 32'ha1c1;

  // request targets of a phase
  localparam int T_MEM  = 0;
  localparam int T_GPIO = 1;
  localparam int T_UART = 2;
  localparam int T_MIX  = 3;

  // expected results of one cycle
  typedef struct packed {
    logic     act;
    logic     rd;
    bus_rsp_t rsp;
    gpio_t    o;
    gpio_t    e;
  } expect_t;

  logic     clk;
  logic     rst_n;
  logic     vld;
  bus_req_t req;
  logic     rdy;
  bus_rsp_t rsp;
  gpio_t    gpio_o;
  gpio_t    gpio_e;
  gpio_t    gpio_i;

  // p1 has its response now, p2 has its pins now
  expect_t  p0;
  expect_t  p1;
  expect_t  p2;
  // gpio_i value and cycles left without GPIO_IN reads
  gpio_t    pin_in;
  int       quiet;
  logic     pins_move;
  mem_adr_t last_idx;

  `include "degu_bus_model.svh"

  degu_bus_top UUT (
    .clk    (clk),
    .rst_n  (rst_n),
    .vld    (vld),
    .req    (req),
    .rdy    (rdy),
    .rsp    (rsp),
    .gpio_o (gpio_o),
    .gpio_e (gpio_e),
    .gpio_i (gpio_i)
  );

  always #(CLK_PERIOD/2) clk = ~clk;

  //////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////

  task automatic stop_run(string msg);
    $display("%s", msg);
    $display("Simulation failed");
    $fatal(1);
  endtask

  // err on every transfer, rdt on reads only
  task automatic check_rsp(bus_rsp_t got, bus_rsp_t want, logic is_read);
    if (got.err !== want.err)
      stop_run($sformatf("ERR %0t: rsp.err is %b, expected %b", $time, got.err, want.err));
    if (is_read && got.rdt !== want.rdt)
      stop_run($sformatf("ERR %0t: rsp.rdt is %08h, expected %08h", $time, got.rdt, want.rdt));
  endtask

  task automatic check_pins(gpio_t got, gpio_t want, string name);
    if (got !== want)
      stop_run($sformatf("ERR %0t: %s is %08h, expected %08h", $time, name, got, want));
  endtask

  //////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////

  // init pattern over the whole word index
  function automatic data_t fill_word(mem_adr_t idx);
    return {~idx, 8'h3c, idx ^ 12'ha5c};
  endfunction

  function automatic bus_req_t random_payload();
    bus_req_t r;
    r.wen = ($urandom_range(0, 1) == 1);
    r.adr = $urandom();
    r.ben = ben_t'($urandom_range(0, 15));
    r.wdt = $urandom();
    return r;
  endfunction

  function automatic bus_req_t mem_request();
    bus_req_t r;
    r = random_payload();
    r.adr[PER_SEL_BIT] = 1'b0;
    // often the last word again, upper bits alias
    if ($urandom_range(0, 3) == 0) r.adr[MEM_ABW+BLOG-1:BLOG] = last_idx;
    last_idx = r.adr[MEM_ABW+BLOG-1:BLOG];
    return r;
  endfunction

  function automatic bus_req_t gpio_request();
    bus_req_t r;
    r = random_payload();
    r.adr[PER_SEL_BIT]  = 1'b1;
    r.adr[UART_SEL_BIT] = 1'b0;
    return r;
  endfunction

  function automatic bus_req_t uart_request();
    bus_req_t r;
    r = random_payload();
    r.adr[PER_SEL_BIT]  = 1'b1;
    r.adr[UART_SEL_BIT] = 1'b1;
    return r;
  endfunction

  // drive one cycle, predict it, check the cycles before
  task automatic drive_cycle(logic v, bus_req_t r);
    expect_t cur;
    @(posedge clk);
    if (quiet > 0) quiet--;
    // no GPIO_IN read while the synchronizer settles
    if (v && quiet > 0 && reads_gpio_in(r)) r.wen = 1'b1;
    if (pins_move && quiet == 0 && !(v && reads_gpio_in(r)) && $urandom_range(0, 7) == 0) begin
      pin_in = $urandom();
      gpio_i <= pin_in;
      quiet  = 3;
    end
    vld <= v;
    req <= r;
    cur.act = v;
    cur.rd  = v && !r.wen;
    cur.rsp = '0;
    if (v) cur.rsp = model_access(r, pin_in);
    cur.o = model_gpio_o;
    cur.e = model_gpio_e;
    p2 = p1;
    p1 = p0;
    p0 = cur;
    @(negedge clk);
    if (rdy !== 1'b1) stop_run($sformatf("ERR %0t: rdy is %b, expected 1", $time, rdy));
    if (p1.act) check_rsp(rsp, p1.rsp, p1.rd);
    check_pins(gpio_o, p2.o, "gpio_o");
    check_pins(gpio_e, p2.e, "gpio_e");
  endtask

  // random idle cycles and back-to-back transfers
  task automatic run_phase(int cycles, int target);
    bus_req_t r;
    logic     v;
    int       pick;
    for (int i = 0; i < cycles; i++) begin
      v    = ($urandom_range(0, 3) != 0);
      pick = (target == T_MIX) ? int'($urandom_range(0, 2)) : target;
      case (pick)
        T_MEM:   r = mem_request();
        T_GPIO:  r = gpio_request();
        default: r = uart_request();
      endcase
      drive_cycle(v, r);
    end
  endtask

  //////////////////////////////////////////////////
  // main sequence and watchdog
  //////////////////////////////////////////////////

  initial begin
    int unsigned seed_ret;
    bus_req_t    r;
    seed_ret  = $urandom(SEED);
    clk       = 1'b0;
    rst_n     = 1'b0;
    vld       = 1'b0;
    req       = '0;
    gpio_i    = '0;
    pin_in    = '0;
    quiet     = 0;
    pins_move = 1'b0;
    last_idx  = '0;
    p0        = '0;
    p1        = '0;
    p2        = '0;
    model_gpio_o = '0;
    model_gpio_e = '0;
    repeat (RST_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    // reset values
    check_pins(gpio_o, '0, "gpio_o after reset");
    check_pins(gpio_e, '0, "gpio_e after reset");
    if (rdy !== 1'b1) stop_run($sformatf("ERR %0t: rdy is %b after reset", $time, rdy));
    // full word writes over the whole memory
    for (int i = 0; i < N_FILL; i++) begin
      r.wen = 1'b1;
      r.adr = addr_t'(i) << BLOG;
      r.ben = '1;
      r.wdt = fill_word(mem_adr_t'(i));
      drive_cycle(1'b1, r);
    end
    run_phase(N_MEM, T_MEM);
    pins_move = 1'b1;
    run_phase(N_GPIO, T_GPIO);
    run_phase(N_UART, T_UART);
    run_phase(N_MIX, T_MIX);
    // flush the last responses and pin updates
    repeat (N_DRAIN) drive_cycle(1'b0, '0);
    $display("Simulation completed successfully");
    $finish;
  end

  initial begin
    #(TIMEOUT_NS);
    stop_run("Timeout: the test did not finish within the watchdog limit");
  end

endmodule

`default_nettype wire

// File: sim.f
+incdir+dv
hw/degu_bus_pkg.sv
hw/lsu_demux.sv
hw/data_memory.sv
hw/peripheral_bus.sv
hw/gpio_controller.sv
hw/degu_bus_top.sv
dv/degu_bus_tb.sv
